//--- flist.f
fetch_pkg.sv
axi_pkg.sv
icache.sv
ifu.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv

//--- fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int          LINES      = 16;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] WORD_KEY   = 32'h5a3c_96e1;
    localparam logic [31:0] ERR_BASE   = 32'h0000_8000;

    logic                   clk;
    logic                   rst;
    logic [31:0]            pc;
    logic                   fetch_ready;
    logic                   fetch_valid;
    fetch_pkg::fetch_resp_t fetch_resp;
    axi_pkg::axi_ar_t       ar;
    logic                   arvalid;
    logic                   arready;
    axi_pkg::axi_r_t        r;
    logic                   rvalid;
    logic                   rready;

    int unsigned ar_count;
    int unsigned errors;
    int unsigned tests_run;
    logic [31:0] last_ar_addr;

    fetch_top #(
        .LINES (LINES)
    ) u_fetch_top (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_resp  (fetch_resp),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    bind fetch_top fetch_props u_fetch_props (
        .clk         (clk),
        .rst         (rst),
        .arvalid     (arvalid),
        .ar          (ar),
        .arready     (arready),
        .rready      (rready),
        .fetch_valid (fetch_valid),
        .fetch_resp  (fetch_resp),
        .fetch_ready (fetch_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    function automatic logic in_err_region(input logic [31:0] addr);
        return (addr >= ERR_BASE) && (addr < ERR_BASE + 32'h100);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("error: %s is %0h, expected %0h", name, got, exp);
        errors++;
    endtask

    // Bus memory model. It serves one read at a time with random stalls on both channels.
    always begin : bus_model
        int unsigned stall;
        int unsigned guard;
        @(negedge clk);
        if (!rst && arvalid) begin
            stall = $urandom % 4;
            repeat (stall) @(negedge clk);
            last_ar_addr = ar.addr;
            arready = 1'b1;
            @(negedge clk);
            arready = 1'b0;
            ar_count++;
            stall = $urandom % 4;
            repeat (stall) @(negedge clk);
            r.data = model_word(last_ar_addr);
            r.resp = in_err_region(last_ar_addr) ? 2'b10 : axi_pkg::RESP_OKAY;
            rvalid = 1'b1;
            guard = 0;
            while (!rready && guard < WAIT_LIMIT) begin
                @(negedge clk);
                guard++;
            end
            if (!rready) begin
                abort_run("timeout: rready never rose after the address transfer");
            end
            @(negedge clk);
            rvalid = 1'b0;
        end
    end

    task automatic wait_result(output fetch_pkg::fetch_resp_t resp,
                               output int unsigned cycles);
        cycles = 0;
        while (!fetch_valid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetch_valid) begin
            abort_run("timeout: fetch_valid never rose");
        end
        resp = fetch_resp;
    endtask

    task automatic take_result();
        fetch_ready = 1'b1;
        @(negedge clk);
        fetch_ready = 1'b0;
    endtask

    // Fetches addr and checks the word, the error flag and the bus reads.
    task automatic expect_fetch(input logic [31:0] addr, input int unsigned exp_reads,
                                output int unsigned cycles);
        fetch_pkg::fetch_resp_t resp;
        int unsigned            reads_before;
        reads_before = ar_count;
        @(negedge clk);
        pc = addr;
        wait_result(resp, cycles);
        take_result();
        if (resp.inst !== model_word(addr)) begin
            report_mismatch("fetch_resp.inst", resp.inst, model_word(addr));
        end
        if (resp.err !== in_err_region(addr)) begin
            report_mismatch("fetch_resp.err", resp.err, in_err_region(addr));
        end
        if (ar_count - reads_before != exp_reads) begin
            report_mismatch("address transfers", ar_count - reads_before, exp_reads);
        end
        if (exp_reads != 0 && last_ar_addr !== addr) begin
            report_mismatch("ar.addr", last_ar_addr, addr);
        end
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        tests_run++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    task automatic test_miss();
        int unsigned errors_before;
        int unsigned cycles;
        errors_before = errors;
        expect_fetch(32'h0000_0100, 1, cycles);
        finish_test("miss fetch", errors_before);
    endtask

    task automatic test_hit();
        int unsigned errors_before;
        int unsigned cycles;
        errors_before = errors;
        expect_fetch(32'h0000_0204, 1, cycles);
        expect_fetch(32'h0000_0100, 0, cycles);
        if (cycles != 3) begin
            report_mismatch("hit latency", cycles, 3);
        end
        finish_test("hit fetch", errors_before);
    endtask

    task automatic test_conflict();
        int unsigned errors_before;
        int unsigned cycles;
        errors_before = errors;
        // Both addresses map to the same line with different tags.
        for (int i = 0; i < 3; i++) begin
            expect_fetch(32'h0000_0340, 1, cycles);
            expect_fetch(32'h0000_0340 + LINES * 4, 1, cycles);
        end
        finish_test("conflict eviction", errors_before);
    endtask

    task automatic test_error();
        int unsigned errors_before;
        int unsigned cycles;
        errors_before = errors;
        expect_fetch(ERR_BASE + 32'h10, 1, cycles);
        expect_fetch(32'h0000_0404, 1, cycles);
        expect_fetch(ERR_BASE + 32'h10, 1, cycles);
        finish_test("error response", errors_before);
    endtask

    task automatic test_backpressure();
        fetch_pkg::fetch_resp_t first;
        fetch_pkg::fetch_resp_t second;
        int unsigned            cycles;
        int unsigned            hold;
        int unsigned            reads_before;
        int unsigned            errors_before;
        errors_before = errors;
        hold = 2 + ($urandom % 8);
        @(negedge clk);
        pc = 32'h0000_0500;
        wait_result(first, cycles);
        if (first.inst !== model_word(32'h0000_0500)) begin
            report_mismatch("fetch_resp.inst", first.inst, model_word(32'h0000_0500));
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (i == 0) begin
                pc = 32'h0000_0608;
            end
            if (!fetch_valid) begin
                $display("fetch_valid dropped while fetch_ready was low");
                errors++;
            end
            if (fetch_resp !== first) begin
                report_mismatch("fetch_resp", fetch_resp, first);
            end
        end
        reads_before = ar_count;
        take_result();
        if (fetch_valid) begin
            $display("fetch_valid stayed high after the decoder took the result");
            errors++;
        end
        // The PC change made during the hold is fetched now.
        wait_result(second, cycles);
        take_result();
        if (second.inst !== model_word(32'h0000_0608)) begin
            report_mismatch("fetch_resp.inst", second.inst, model_word(32'h0000_0608));
        end
        if (ar_count - reads_before != 1) begin
            report_mismatch("address transfers", ar_count - reads_before, 1);
        end
        finish_test("back-pressure", errors_before);
    endtask

    task automatic test_reset();
        fetch_pkg::fetch_resp_t held;
        int unsigned            errors_before;
        int unsigned            cycles;
        int unsigned            reads_before;
        errors_before = errors;
        expect_fetch(32'h0000_0728, 1, cycles);
        expect_fetch(32'h0000_0830, 1, cycles);
        expect_fetch(32'h0000_0728, 0, cycles);
        // Reset arrives while a result is still waiting for the decoder.
        @(negedge clk);
        pc = 32'h0000_0934;
        wait_result(held, cycles);
        @(negedge clk);
        rst = 1'b1;
        pc  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        reads_before = ar_count;
        if (fetch_valid || arvalid || rready) begin
            $display("fetch_valid, arvalid or rready was high right after reset");
            errors++;
        end
        // PC 0 equals the reset value of the last PC, so nothing starts.
        repeat (4) @(negedge clk);
        if (fetch_valid || arvalid || ar_count != reads_before) begin
            $display("a fetch started at PC 0 right after reset");
            errors++;
        end
        expect_fetch(32'h0000_0728, 1, cycles);
        finish_test("reset state", errors_before);
    endtask

    initial begin
        void'($urandom(32'h928d));
        clk          = 1'b0;
        rst          = 1'b1;
        pc           = '0;
        fetch_ready  = 1'b0;
        arready      = 1'b0;
        rvalid       = 1'b0;
        r            = '0;
        ar_count     = 0;
        errors       = 0;
        tests_run    = 0;
        last_ar_addr = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        test_miss();
        test_hit();
        test_conflict();
        test_error();
        test_backpressure();
        test_reset();

        errors += u_fetch_top.u_fetch_props.fails;
        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_props.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the bus read channels and the decoder output.
module fetch_props (
    input logic                   clk,
    input logic                   rst,
    input logic                   arvalid,
    input axi_pkg::axi_ar_t       ar,
    input logic                   arready,
    input logic                   rready,
    input logic                   fetch_valid,
    input fetch_pkg::fetch_resp_t fetch_resp,
    input logic                   fetch_ready
);

    int unsigned fails = 0;

    property ar_held;
        @(posedge clk) disable iff (rst)
            arvalid && !arready |=> arvalid && $stable(ar);
    endproperty

    // rready may only rise in the cycle after an address transfer.
    property rready_after_addr;
        @(posedge clk) disable iff (rst)
            $rose(rready) |-> $past(arvalid && arready);
    endproperty

    property result_held;
        @(posedge clk) disable iff (rst)
            fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_resp);
    endproperty

    a_ar_held: assert property (ar_held)
    else begin
        $error("arvalid or ar changed before arready");
        fails++;
    end

    a_rready_after_addr: assert property (rready_after_addr)
    else begin
        $error("rready rose without a preceding address transfer");
        fails++;
    end

    a_result_held: assert property (result_held)
    else begin
        $error("fetch_valid or fetch_resp changed before fetch_ready");
        fails++;
    end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction-fetch front end: fetch control plus its instruction cache.
module fetch_top #(
    parameter int LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                pc,
    input  logic                       fetch_ready,
    output logic                       fetch_valid,
    output fetch_pkg::fetch_resp_t     fetch_resp,
    output axi_pkg::axi_ar_t           ar,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_pkg::axi_r_t            r,
    input  logic                       rvalid,
    output logic                       rready
);

    logic                       lookup;
    logic [fetch_pkg::XLEN-1:0] lookup_addr;
    logic                       hit;
    logic [fetch_pkg::XLEN-1:0] hit_data;
    logic                       miss;
    logic                       fill;
    logic [fetch_pkg::XLEN-1:0] fill_addr;
    logic [fetch_pkg::XLEN-1:0] fill_data;

    ifu u_ifu (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_resp  (fetch_resp),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .lookup      (lookup),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_data    (hit_data),
        .miss        (miss),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data)
    );

    icache #(
        .LINES (LINES)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_data    (hit_data),
        .miss        (miss),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data)
    );

endmodule

`default_nettype wire

//--- ifu.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch control. Watches the PC, asks the cache, falls back to a single
// bus read on a miss and holds the result until the decoder takes it.
module ifu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::XLEN-1:0] pc,
    input  logic                       fetch_ready,
    output logic                       fetch_valid,
    output fetch_pkg::fetch_resp_t     fetch_resp,
    output axi_pkg::axi_ar_t           ar,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_pkg::axi_r_t            r,
    input  logic                       rvalid,
    output logic                       rready,
    output logic                       lookup,
    output logic [fetch_pkg::XLEN-1:0] lookup_addr,
    input  logic                       hit,
    input  logic [fetch_pkg::XLEN-1:0] hit_data,
    input  logic                       miss,
    output logic                       fill,
    output logic [fetch_pkg::XLEN-1:0] fill_addr,
    output logic [fetch_pkg::XLEN-1:0] fill_data
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ADDR,
        DATA,
        HOLD
    } state_t;

    state_t                     state;
    logic [fetch_pkg::XLEN-1:0] last_pc;
    logic                       hit_take;
    logic                       r_take;
    logic                       r_okay;

    // The latched PC is the address of the fetch in flight. It only moves
    // in IDLE, so the bus address stays stable while arvalid is high.
    assign lookup_addr = last_pc;
    assign ar.addr     = last_pc;
    assign fill_addr   = last_pc;
    assign fill_data   = r.data;

    assign hit_take = (state == LOOKUP) && hit;
    assign r_take   = (state == DATA) && rvalid && rready;
    assign r_okay   = (r.resp == axi_pkg::RESP_OKAY);

    // Erroneous reads are passed on but never cached.
    assign fill = r_take && r_okay;

    // Hit path: lookup one cycle after the PC change is sampled, hit one
    // cycle later, fetch_valid the cycle after that.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            last_pc     <= '0;
            lookup      <= 1'b0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            lookup <= 1'b0;
            case (state)
                IDLE: begin
                    if (pc != last_pc) begin
                        last_pc <= pc;
                        lookup  <= 1'b1;
                        state   <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit_take) begin
                        fetch_valid <= 1'b1;
                        state       <= HOLD;
                    end else if (miss) begin
                        arvalid <= 1'b1;
                        state   <= ADDR;
                    end
                end
                ADDR: begin
                    // Data is only accepted once the address has gone out.
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (r_take) begin
                        rready      <= 1'b0;
                        fetch_valid <= 1'b1;
                        state       <= HOLD;
                    end
                end
                HOLD: begin
                    // A PC change seen here is picked up again in IDLE.
                    if (fetch_ready) begin
                        fetch_valid <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Result payload, loaded only when a fetch completes.
    always_ff @(posedge clk) begin
        if (hit_take) begin
            fetch_resp.inst <= hit_data;
            fetch_resp.err  <= 1'b0;
        end else if (r_take) begin
            fetch_resp.inst <= r.data;
            fetch_resp.err  <= !r_okay;
        end
    end

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ps
`default_nettype none

// Direct-mapped instruction cache with one word per line.
// Lookups answer exactly one cycle later with a hit or a miss pulse.
module icache #(
    parameter int LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lookup,
    input  logic [fetch_pkg::XLEN-1:0] lookup_addr,
    output logic                       hit,
    output logic [fetch_pkg::XLEN-1:0] hit_data,
    output logic                       miss,
    input  logic                       fill,
    input  logic [fetch_pkg::XLEN-1:0] fill_addr,
    input  logic [fetch_pkg::XLEN-1:0] fill_data
);

    // Bits 1:0 select a byte in the word and take no part in the index.
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = fetch_pkg::XLEN - IDX_W - 2;

    typedef struct packed {
        logic [TAG_W-1:0]           tag;
        logic [fetch_pkg::XLEN-1:0] word;
    } line_t;

    logic [LINES-1:0] valid;
    line_t            lines [LINES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] fl_idx;
    logic [TAG_W-1:0] fl_tag;
    logic             lk_match;

    assign lk_idx = lookup_addr[IDX_W+1:2];
    assign lk_tag = lookup_addr[fetch_pkg::XLEN-1:IDX_W+2];
    assign fl_idx = fill_addr[IDX_W+1:2];
    assign fl_tag = fill_addr[fetch_pkg::XLEN-1:IDX_W+2];

    assign lk_match = valid[lk_idx] && (lines[lk_idx].tag == lk_tag);

    // Control state: valid bits and the answer pulses.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            hit   <= 1'b0;
            miss  <= 1'b0;
        end else begin
            hit  <= lookup && lk_match;
            miss <= lookup && !lk_match;
            if (fill) begin
                valid[fl_idx] <= 1'b1;
            end
        end
    end

    // Storage. A fill simply overwrites the indexed line.
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[fl_idx].tag  <= fl_tag;
            lines[fl_idx].word <= fill_data;
        end
        if (lookup) begin
            hit_data <= lines[lk_idx].word;
        end
    end

endmodule

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

// Read-channel types of the external instruction bus.
package axi_pkg;

    localparam int AXI_AW = 32;
    localparam int AXI_DW = 32;

    // Response code of a successful read.
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Read-address channel payload.
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
    } axi_ar_t;

    // Read-data channel payload.
    typedef struct packed {
        logic [AXI_DW-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

endpackage

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

// Types seen on the core side of the fetch path.
package fetch_pkg;

    // Width of program addresses and instruction words.
    localparam int XLEN = 32;

    // What the decoder receives for one fetch.
    // The err bit is set when the bus answered with a non-OKAY response,
    // in which case inst carries whatever data the bus returned.
    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic            err;
    } fetch_resp_t;

endpackage

`default_nettype wire
